/* source/pitch_frame_pkg.sv */
package pitch_frame_pkg;

	////////////////////////////////////////
	// frame geometry

	localparam int FRAME_LEN = 80;    // new samples per frame
	localparam int PIT_MIN = 20;
	localparam int PIT_MAX = 143;
	localparam int HIST_LEN = PIT_MAX + FRAME_LEN;

	////////////////////////////////////////
	// lag sections

	localparam int SECTION1_LO = 4 * PIT_MIN;    // section 1 is 80..143
	localparam int SECTION2_LO = 2 * PIT_MIN;    // section 2 is 40..79

	// window index wide enough for HIST_LEN entries
	localparam int BUF_ADDR_W = 8;

	typedef logic [BUF_ADDR_W-1:0] buf_addr_t;
	typedef logic [7:0] lag_t;

endpackage

/* source/pitch_fixed_pkg.sv */
package pitch_fixed_pkg;

	typedef logic signed [15:0] sample_t;
	typedef logic signed [31:0] acc_t;

	localparam int THRESH_Q15 = 27853;    // 0.85 in q15
	localparam int ENERGY_LOW = 1048576;  // 2^20
	localparam int SCALE_SHIFT = 3;

	localparam acc_t ACC_MAX = 32'sh7fff_ffff;
	localparam acc_t ACC_MIN = 32'sh8000_0000;
	localparam sample_t SAMPLE_MAX = 16'sh7fff;
	localparam sample_t SAMPLE_MIN = 16'sh8000;

	////////////////////////////////////////
	// saturating arithmetic

	// acc + 2*a*b, returned as {saturated, sum}
	function automatic logic [32:0] l_mac_sat(
		input acc_t acc,
		input sample_t a,
		input sample_t b
	);
		logic signed [33:0] prod;
		logic signed [33:0] sum;
		prod = a * b;
		sum = acc + (prod <<< 1);    // 34 bits hold the worst case
		if (sum > ACC_MAX)
			return {1'b1, ACC_MAX};
		else if (sum < ACC_MIN)
			return {1'b1, ACC_MIN};
		return {1'b0, sum[31:0]};
	endfunction

	function automatic sample_t shl_sat(input sample_t x, input int unsigned sh);
		logic signed [31:0] wide;
		wide = x;
		wide = wide <<< sh;
		if (wide > SAMPLE_MAX)
			return SAMPLE_MAX;
		else if (wide < SAMPLE_MIN)
			return SAMPLE_MIN;
		return wide[15:0];
	endfunction

	// x * 0.85, rounded toward minus infinity
	function automatic acc_t thresh_q15(input acc_t x);
		logic signed [47:0] prod;
		prod = x * THRESH_Q15;
		return acc_t'(prod >>> 15);
	endfunction

endpackage

/* source/frame_scaler.sv */
`timescale 1ns/1ps

module frame_scaler
	import pitch_frame_pkg::*, pitch_fixed_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  sample_t   sample,
	input  logic      sample_valid,
	output logic      sample_ready,
	input  logic      frame_release,
	output logic      scaled_start,
	input  buf_addr_t cur_addr_a,
	input  buf_addr_t lag_addr_a,
	input  buf_addr_t cur_addr_b,
	input  buf_addr_t lag_addr_b,
	output sample_t   cur_sample_a,
	output sample_t   lag_sample_a,
	output sample_t   cur_sample_b,
	output sample_t   lag_sample_b
);

	sample_t raw_win [HIST_LEN];     // oldest sample at index 0
	sample_t scaled_win [HIST_LEN];

	logic [6:0] fill_cnt;
	buf_addr_t idx;
	logic energy_pass;
	logic scale_pass;
	logic searching;
	acc_t energy;
	acc_t energy_next;
	logic energy_ovf;
	logic mac_sat;
	sample_t raw_cur;
	sample_t scaled_val;

	// no new samples while a frame is being processed
	assign sample_ready = !(energy_pass || scale_pass || searching);
	assign raw_cur = raw_win[idx];

	always_comb
	begin
		{mac_sat, energy_next} = l_mac_sat(energy, raw_cur, raw_cur);
	end

	always_comb
	begin
		if (energy_ovf)
			scaled_val = raw_cur >>> SCALE_SHIFT;
		else if (energy < ENERGY_LOW)
			scaled_val = shl_sat(raw_cur, SCALE_SHIFT);  // quiet frame, boost
		else
			scaled_val = raw_cur;
	end

	////////////////////////////////////////
	// history window

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < HIST_LEN; i++)
				raw_win[i] <= '0;
		end
		else if (sample_valid && sample_ready)
		begin
			for (int i = 0; i < HIST_LEN - 1; i++)
				raw_win[i] <= raw_win[i+1];
			raw_win[HIST_LEN-1] <= sample;
		end
	end

	////////////////////////////////////////
	// energy and scaling passes

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			fill_cnt <= '0;
			idx <= '0;
			energy_pass <= 1'b0;
			scale_pass <= 1'b0;
			searching <= 1'b0;
			scaled_start <= 1'b0;
		end
		else
		begin
			scaled_start <= 1'b0;
			if (sample_valid && sample_ready)
			begin
				if (fill_cnt == FRAME_LEN - 1)
				begin
					fill_cnt <= '0;
					idx <= '0;
					energy_pass <= 1'b1;
				end
				else
					fill_cnt <= fill_cnt + 1'b1;
			end
			if (energy_pass)
			begin
				if (idx == HIST_LEN - 1)
				begin
					idx <= '0;
					energy_pass <= 1'b0;
					scale_pass <= 1'b1;
				end
				else
					idx <= idx + 1'b1;
			end
			if (scale_pass)
			begin
				if (idx == HIST_LEN - 1)
				begin
					scale_pass <= 1'b0;
					searching <= 1'b1;
					scaled_start <= 1'b1;  // last scaled word written this edge
				end
				else
					idx <= idx + 1'b1;
			end
			if (searching && frame_release)
				searching <= 1'b0;
		end
	end

	// energy restarts from zero with each frame
	always_ff @(posedge clk)
	begin
		if (sample_valid && sample_ready && fill_cnt == FRAME_LEN - 1)
		begin
			energy <= '0;
			energy_ovf <= 1'b0;
		end
		else if (energy_pass)
		begin
			energy <= energy_next;
			if (mac_sat)
				energy_ovf <= 1'b1;   // sticky
		end
	end

	always_ff @(posedge clk)
	begin
		if (scale_pass)
			scaled_win[idx] <= scaled_val;
	end

	// read ports, same cycle
	assign cur_sample_a = scaled_win[cur_addr_a];
	assign lag_sample_a = scaled_win[lag_addr_a];
	assign cur_sample_b = scaled_win[cur_addr_b];
	assign lag_sample_b = scaled_win[lag_addr_b];

endmodule

/* source/lag_correlator.sv */
`timescale 1ns/1ps

module lag_correlator
	import pitch_frame_pkg::*, pitch_fixed_pkg::*;
#(
	parameter int LAG_LO = SECTION1_LO,
	parameter int LAG_HI = PIT_MAX
)
(
	input  logic      clk,
	input  logic      reset,
	input  logic      start,
	output buf_addr_t cur_addr,
	output buf_addr_t lag_addr,
	input  sample_t   cur_sample,
	input  sample_t   lag_sample,
	output lag_t      cor_lag,
	output acc_t      cor_value,
	output logic      cor_last,
	output logic      cor_valid,
	input  logic      cor_ready
);

	logic busy;
	logic [6:0] n;     // position inside the current frame
	acc_t acc;
	acc_t acc_next;

	// current frame starts at PIT_MAX, the delayed copy cor_lag samples earlier
	assign cur_addr = buf_addr_t'(PIT_MAX + int'(n));
	assign lag_addr = buf_addr_t'(PIT_MAX + int'(n) - int'(cor_lag));

	assign cor_value = acc;
	assign cor_last = (cor_lag == lag_t'(LAG_LO));

	// keep the sum, drop the saturation bit
	always_comb
	begin
		acc_next = acc_t'(l_mac_sat(acc, cur_sample, lag_sample));
	end

	////////////////////////////////////////
	// lag sweep, highest lag first

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			cor_valid <= 1'b0;
			n <= '0;
			cor_lag <= lag_t'(LAG_HI);
		end
		else if (!busy)
		begin
			if (start)
			begin
				busy <= 1'b1;
				n <= '0;
				cor_lag <= lag_t'(LAG_HI);
			end
		end
		else if (cor_valid)
		begin
			// hold until the selector takes it
			if (cor_ready)
			begin
				cor_valid <= 1'b0;
				n <= '0;
				if (cor_last)
					busy <= 1'b0;
				else
					cor_lag <= cor_lag - 1'b1;
			end
		end
		else
		begin
			if (n == FRAME_LEN - 1)
				cor_valid <= 1'b1;   // 80th term goes in this edge
			else
				n <= n + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if ((!busy && start) || (cor_valid && cor_ready))
			acc <= '0;
		else if (busy && !cor_valid)
			acc <= acc_next;
	end

endmodule

/* source/pitch_selector.sv */
`timescale 1ns/1ps

module pitch_selector
	import pitch_frame_pkg::*, pitch_fixed_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  lag_t cor_lag_a,
	input  acc_t cor_value_a,
	input  logic cor_last_a,
	input  logic cor_valid_a,
	output logic cor_ready_a,
	input  lag_t cor_lag_b,
	input  acc_t cor_value_b,
	input  logic cor_last_b,
	input  logic cor_valid_b,
	output logic cor_ready_b,
	output lag_t pitch_lag,
	output logic pitch_valid,
	input  logic pitch_ready,
	output logic frame_release
);

	acc_t max1, max2, max3;
	lag_t lag1, lag2, lag3;
	acc_t best_max;
	lag_t best_lag;
	logic done_a, done_b;
	logic decide;      // first comparison
	logic step2;       // second comparison
	logic take_a, take_b;

	assign decide = done_a && done_b;
	assign cor_ready_a = !(decide || step2 || pitch_valid);
	assign cor_ready_b = !(decide || step2 || pitch_valid);
	assign take_a = cor_valid_a && cor_ready_a;
	assign take_b = cor_valid_b && cor_ready_b;
	assign frame_release = pitch_valid && pitch_ready;

	////////////////////////////////////////
	// per-section maxima

	always_ff @(posedge clk)
	begin
		if (reset || frame_release)
		begin
			max1 <= ACC_MIN;
			max2 <= ACC_MIN;
			max3 <= ACC_MIN;
			lag1 <= lag_t'(PIT_MAX);
			lag2 <= lag_t'(SECTION1_LO - 1);
			lag3 <= lag_t'(SECTION2_LO - 1);
		end
		else
		begin
			// strict compare so ties keep the higher lag
			if (take_a && cor_value_a > max1)
			begin
				max1 <= cor_value_a;
				lag1 <= cor_lag_a;
			end
			if (take_b)
			begin
				if (cor_lag_b >= SECTION2_LO)
				begin
					if (cor_value_b > max2)
					begin
						max2 <= cor_value_b;
						lag2 <= cor_lag_b;
					end
				end
				else if (cor_value_b > max3)
				begin
					max3 <= cor_value_b;
					lag3 <= cor_lag_b;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			done_a <= 1'b0;
			done_b <= 1'b0;
			step2 <= 1'b0;
			pitch_valid <= 1'b0;
		end
		else
		begin
			if (take_a && cor_last_a)
				done_a <= 1'b1;
			if (take_b && cor_last_b)
				done_b <= 1'b1;
			if (decide)
			begin
				done_a <= 1'b0;
				done_b <= 1'b0;
				step2 <= 1'b1;
			end
			if (step2)
			begin
				step2 <= 1'b0;
				pitch_valid <= 1'b1;
			end
			if (frame_release)
				pitch_valid <= 1'b0;
		end
	end

	////////////////////////////////////////
	// short lag preference

	always_ff @(posedge clk)
	begin
		if (decide)
		begin
			if (thresh_q15(max1) < max2)
			begin
				best_max <= max2;
				best_lag <= lag2;
			end
			else
			begin
				best_max <= max1;
				best_lag <= lag1;
			end
		end
		if (step2)
			pitch_lag <= (thresh_q15(best_max) < max3) ? lag3 : best_lag;
	end

endmodule

/* source/pitch_estimator_top.sv */
`timescale 1ns/1ps

module pitch_estimator_top
(
	input  logic                     clk,
	input  logic                     reset,
	input  pitch_fixed_pkg::sample_t sample,
	input  logic                     sample_valid,
	output logic                     sample_ready,
	output pitch_frame_pkg::lag_t    pitch_lag,
	output logic                     pitch_valid,
	input  logic                     pitch_ready
);

	logic scaled_start;
	logic frame_release;

	// read ports, a for section 1 and b for sections 2 and 3
	pitch_frame_pkg::buf_addr_t cur_addr_a, lag_addr_a;
	pitch_frame_pkg::buf_addr_t cur_addr_b, lag_addr_b;
	pitch_fixed_pkg::sample_t cur_sample_a, lag_sample_a;
	pitch_fixed_pkg::sample_t cur_sample_b, lag_sample_b;

	// correlation streams
	pitch_frame_pkg::lag_t cor_lag_a, cor_lag_b;
	pitch_fixed_pkg::acc_t cor_value_a, cor_value_b;
	logic cor_last_a, cor_last_b;
	logic cor_valid_a, cor_valid_b;
	logic cor_ready_a, cor_ready_b;

	frame_scaler frame_scaler_inst (
		.clk           (clk),
		.reset         (reset),
		.sample        (sample),
		.sample_valid  (sample_valid),
		.sample_ready  (sample_ready),
		.frame_release (frame_release),
		.scaled_start  (scaled_start),
		.cur_addr_a    (cur_addr_a),
		.lag_addr_a    (lag_addr_a),
		.cur_addr_b    (cur_addr_b),
		.lag_addr_b    (lag_addr_b),
		.cur_sample_a  (cur_sample_a),
		.lag_sample_a  (lag_sample_a),
		.cur_sample_b  (cur_sample_b),
		.lag_sample_b  (lag_sample_b)
	);

	lag_correlator #(
		.LAG_LO (pitch_frame_pkg::SECTION1_LO),
		.LAG_HI (pitch_frame_pkg::PIT_MAX)
	) correlator_a_inst (
		.clk        (clk),
		.reset      (reset),
		.start      (scaled_start),
		.cur_addr   (cur_addr_a),
		.lag_addr   (lag_addr_a),
		.cur_sample (cur_sample_a),
		.lag_sample (lag_sample_a),
		.cor_lag    (cor_lag_a),
		.cor_value  (cor_value_a),
		.cor_last   (cor_last_a),
		.cor_valid  (cor_valid_a),
		.cor_ready  (cor_ready_a)
	);

	lag_correlator #(
		.LAG_LO (pitch_frame_pkg::PIT_MIN),
		.LAG_HI (pitch_frame_pkg::SECTION1_LO - 1)
	) correlator_b_inst (
		.clk        (clk),
		.reset      (reset),
		.start      (scaled_start),
		.cur_addr   (cur_addr_b),
		.lag_addr   (lag_addr_b),
		.cur_sample (cur_sample_b),
		.lag_sample (lag_sample_b),
		.cor_lag    (cor_lag_b),
		.cor_value  (cor_value_b),
		.cor_last   (cor_last_b),
		.cor_valid  (cor_valid_b),
		.cor_ready  (cor_ready_b)
	);

	pitch_selector pitch_selector_inst (
		.clk           (clk),
		.reset         (reset),
		.cor_lag_a     (cor_lag_a),
		.cor_value_a   (cor_value_a),
		.cor_last_a    (cor_last_a),
		.cor_valid_a   (cor_valid_a),
		.cor_ready_a   (cor_ready_a),
		.cor_lag_b     (cor_lag_b),
		.cor_value_b   (cor_value_b),
		.cor_last_b    (cor_last_b),
		.cor_valid_b   (cor_valid_b),
		.cor_ready_b   (cor_ready_b),
		.pitch_lag     (pitch_lag),
		.pitch_valid   (pitch_valid),
		.pitch_ready   (pitch_ready),
		.frame_release (frame_release)
	);

endmodule

/* testbench/pitch_reference.svh */
localparam longint ACC_TOP = 64'sd2147483647;
localparam longint ACC_BOTTOM = -ACC_TOP - 1;
localparam int PATH_COPY = 0;
localparam int PATH_BOOST = 1;
localparam int PATH_CUT = 2;

sample_t history [HIST_LEN];    // oldest sample at index 0
sample_t scaled [HIST_LEN];

function automatic void clear_history();
	for (int i = 0; i < HIST_LEN; i++)
		history[i] = '0;
endfunction

function automatic void push_history(input sample_t s);
	for (int i = 0; i < HIST_LEN - 1; i++)
		history[i] = history[i+1];
	history[HIST_LEN-1] = s;
endfunction

function automatic longint clamp_acc(input longint v);
	if (v > ACC_TOP)
		return ACC_TOP;
	else if (v < ACC_BOTTOM)
		return ACC_BOTTOM;
	return v;
endfunction

////////////////////////////////////////
// energy and rescaling of the window

function automatic int scale_history();
	longint energy;
	longint v;
	int path;
	energy = 0;
	for (int i = 0; i < HIST_LEN; i++)
		energy = energy + 2 * longint'(history[i]) * longint'(history[i]);
	if (energy > ACC_TOP)
		path = PATH_CUT;       // saturated energy
	else if (energy < ENERGY_LOW)
		path = PATH_BOOST;
	else
		path = PATH_COPY;
	for (int i = 0; i < HIST_LEN; i++)
	begin
		v = history[i];
		if (path == PATH_CUT)
			v = v >>> SCALE_SHIFT;
		else if (path == PATH_BOOST)
			v = v * (64'sd1 << SCALE_SHIFT);
		if (v > 32767)
			v = 32767;
		else if (v < -32768)
			v = -32768;
		scaled[i] = sample_t'(v);
	end
	return path;
endfunction

////////////////////////////////////////
// lag search and short lag preference

function automatic longint lag_correlation(input int lag);
	longint acc;
	longint term;
	acc = 0;
	for (int n = 0; n < FRAME_LEN; n++)
	begin
		term = 2 * longint'(scaled[PIT_MAX+n]) * longint'(scaled[PIT_MAX+n-lag]);
		acc = clamp_acc(acc + term);   // saturates at every step
	end
	return acc;
endfunction

// 27853/32768 of x, floor
function automatic longint preference_bound(input longint x);
	return (x * THRESH_Q15) >>> 15;
endfunction

function automatic int search_pitch_lag();
	longint c;
	longint max1, max2, max3;
	longint best;
	int lag1, lag2, lag3;
	int best_lag;
	max1 = ACC_BOTTOM;
	max2 = ACC_BOTTOM;
	max3 = ACC_BOTTOM;
	lag1 = PIT_MAX;
	lag2 = SECTION1_LO - 1;
	lag3 = SECTION2_LO - 1;
	for (int t = PIT_MAX; t >= PIT_MIN; t--)
	begin
		c = lag_correlation(t);
		if (t >= SECTION1_LO && c > max1)
		begin
			max1 = c;
			lag1 = t;
		end
		if (t >= SECTION2_LO && t < SECTION1_LO && c > max2)
		begin
			max2 = c;
			lag2 = t;
		end
		if (t < SECTION2_LO && c > max3)
		begin
			max3 = c;
			lag3 = t;
		end
	end
	best = max1;
	best_lag = lag1;
	if (preference_bound(best) < max2)
	begin
		best = max2;
		best_lag = lag2;
	end
	if (preference_bound(best) < max3)
		best_lag = lag3;
	return best_lag;
endfunction

/* testbench/pitch_estimator_tb.sv */
`timescale 1ns/1ps

module pitch_estimator_tb
	import pitch_frame_pkg::*, pitch_fixed_pkg::*;
();

	localparam int NUM_FRAMES = 12;
	localparam int CLK_PERIOD = 10;
	localparam int FRAME_CYCLES = FRAME_LEN + 446 + 124 * 81 + 200;
	localparam int STALL_MARGIN = 600;    // sample gaps and slow pitch_ready
	localparam int TIMEOUT_NS = (NUM_FRAMES * (FRAME_CYCLES + STALL_MARGIN) + 20) * CLK_PERIOD;

	localparam int KIND_LOW = 0;
	localparam int KIND_MID = 1;
	localparam int KIND_FULL = 2;
	localparam int KIND_PERIODIC = 3;

	logic clk;
	logic reset;
	sample_t sample;
	logic sample_valid;
	logic sample_ready;
	lag_t pitch_lag;
	logic pitch_valid;
	logic pitch_ready;

	int expected_q [$];
	int frames_sent;
	int results_done;
	int stream_pos;      // accepted samples so far, drives the periodic phase

	`include "pitch_reference.svh"

	pitch_estimator_top pitch_estimator_top_inst (
		.clk          (clk),
		.reset        (reset),
		.sample       (sample),
		.sample_valid (sample_valid),
		.sample_ready (sample_ready),
		.pitch_lag    (pitch_lag),
		.pitch_valid  (pitch_valid),
		.pitch_ready  (pitch_ready)
	);

	initial
		clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("MISMATCH at %0t ns: %s, got %0d, expected %0d", $time, what, actual,
				expected);
			$display("Test failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	////////////////////////////////////////
	// stimulus

	// low, mid, full scale, then periods 30, 57 and 100
	function automatic int frame_kind(input int f);
		if (f < 2)
			return KIND_LOW;
		else if (f < 4)
			return KIND_MID;
		else if (f < 6)
			return KIND_FULL;
		return KIND_PERIODIC;
	endfunction

	function automatic int frame_period(input int f);
		if (f < 8)
			return 30;
		else if (f < 10)
			return 57;
		return 100;
	endfunction

	function automatic sample_t next_stimulus(input int kind, input int period, input int t);
		int phase;
		int noise;
		int value;
		phase = t % period;
		noise = int'($urandom_range(400)) - 200;
		case (kind)
			KIND_LOW: value = int'($urandom_range(120)) - 60;
			KIND_MID: value = int'($urandom_range(4000)) - 2000;
			KIND_FULL: value = int'($urandom);           // low 16 bits used
			default: value = (phase < 5) ? 5000 - 1200 * phase + noise : noise;
		endcase
		return sample_t'(value);
	endfunction

	task automatic feed_frame(input int f);
		int taken;
		int path;
		int lag;
		taken = 0;
		while (taken < FRAME_LEN)
		begin
			@(negedge clk);
			if ($urandom_range(3) == 0)
				sample_valid = 1'b0;    // gap
			else
			begin
				sample = next_stimulus(frame_kind(f), frame_period(f), stream_pos);
				sample_valid = 1'b1;
				check_equal(sample_ready, 1, $sformatf("sample_ready in intake of frame %0d", f));
				push_history(sample);
				stream_pos++;
				taken++;
			end
		end
		path = scale_history();
		lag = search_pitch_lag();
		expected_q.push_back(lag);
		frames_sent++;
		$display("frame %0d: scaling path %s, expected lag %0d", f,
			(path == PATH_CUT) ? "shift right" : (path == PATH_BOOST) ? "shift left" : "copy",
			lag);
	endtask

	// offers stray samples that must be refused until the result is taken
	task automatic wait_for_release(input int f);
		logic pending;
		pending = 1'b1;
		while (pending)
		begin
			@(negedge clk);
			if (results_done == frames_sent)
			begin
				sample_valid = 1'b0;
				pending = 1'b0;
			end
			else
			begin
				check_equal(sample_ready, 0, $sformatf("sample_ready while frame %0d pending", f));
				sample = sample_t'($urandom);
				sample_valid = ($urandom_range(1) == 1);
			end
		end
	endtask

	initial
	begin
		void'($urandom(32'hbaee511b));
		reset = 1'b1;
		sample = '0;
		sample_valid = 1'b0;
		pitch_ready = 1'b0;
		frames_sent = 0;
		results_done = 0;
		stream_pos = 0;
		clear_history();
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_equal(sample_ready, 1, "sample_ready after reset");
		check_equal(pitch_valid, 0, "pitch_valid after reset");
		for (int f = 0; f < NUM_FRAMES; f++)
		begin
			feed_frame(f);
			wait_for_release(f);
		end
		$display("Test passed");
		$finish;
	end

	////////////////////////////////////////
	// result checker

	initial
	begin : result_checker
		int frame;
		logic shown;
		lag_t held_lag;
		frame = 0;
		shown = 1'b0;
		wait (reset === 1'b0);
		forever
		begin
			@(negedge clk);
			if (pitch_valid === 1'b1)
			begin
				if (shown)
					check_equal(pitch_lag, held_lag, $sformatf("stalled pitch_lag, frame %0d", frame));
				else if (expected_q.size() == 0)
				begin
					$display("a pitch result arrived with no frame outstanding");
					$display("Test failed");
					$fatal(1, "unexpected result");
				end
				else
				begin
					check_equal(pitch_lag, expected_q.pop_front(),
						$sformatf("pitch lag of frame %0d", frame));
					held_lag = pitch_lag;
					shown = 1'b1;
				end
				pitch_ready = ($urandom_range(2) == 0);
				if (pitch_ready)
				begin
					@(posedge clk);    // handshake completes here
					results_done++;
					frame++;
					shown = 1'b0;
				end
			end
			else
				pitch_ready = ($urandom_range(1) == 1);   // ready ahead of valid is harmless
		end
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("timeout after %0d ns, no pitch result arrived in time", TIMEOUT_NS);
		$display("Test failed");
		$fatal(1, "watchdog expired");
	end

endmodule

/* project.f */
+incdir+testbench
source/pitch_frame_pkg.sv
source/pitch_fixed_pkg.sv
source/frame_scaler.sv
source/lag_correlator.sv
source/pitch_selector.sv
source/pitch_estimator_top.sv
testbench/pitch_estimator_tb.sv
